//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module core_tb -f tb.f -o core_tb_sim
./obj_dir/core_tb_sim +verilator+error+limit+10

//--- source/bus_arbiter.sv
`timescale 1ns/100ps

module bus_arbiter
  import core_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            if_req_i,
  input  logic [xlen-1:0] if_addr_i,
  input  logic            ls_req_i,
  input  logic            ls_we_i,
  input  logic [xlen-1:0] ls_addr_i,
  input  logic [xlen-1:0] ls_wdata_i,
  input  logic            mem_ack_i,
  input  logic [xlen-1:0] mem_rdata_i,
  output logic            if_ack_o,
  output logic [xlen-1:0] if_rdata_o,
  output logic            ls_ack_o,
  output logic [xlen-1:0] ls_rdata_o,
  output logic            mem_req_o,
  output logic            mem_we_o,
  output logic [xlen-1:0] mem_addr_o,
  output logic [xlen-1:0] mem_wdata_o,
  output logic [3:0]      mem_wstrb_o
);

  typedef enum logic [1:0] {OWN_NONE, OWN_IF, OWN_LS} owner_e;

  owner_e owner;
  logic   sel_if;
  logic   sel_ls;

  // Data side wins a tie
  assign sel_ls = (owner == OWN_LS) || (owner == OWN_NONE && ls_req_i);
  assign sel_if = (owner == OWN_IF) || (owner == OWN_NONE && !ls_req_i && if_req_i);

  assign mem_req_o   = (sel_ls && ls_req_i) || (sel_if && if_req_i);
  assign mem_we_o    = sel_ls && ls_we_i;
  assign mem_addr_o  = sel_ls ? ls_addr_i : if_addr_i;
  assign mem_wdata_o = ls_wdata_i;
  assign mem_wstrb_o = (sel_ls && ls_we_i) ? 4'hf : 4'h0;

  assign if_ack_o   = sel_if && mem_ack_i;
  assign ls_ack_o   = sel_ls && mem_ack_i;
  assign if_rdata_o = mem_rdata_i;
  assign ls_rdata_o = mem_rdata_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      owner <= OWN_NONE;
    end
    else if (mem_req_o && mem_ack_i)
    begin
      owner <= OWN_NONE;
    end
    else if (owner == OWN_NONE && mem_req_o)
    begin
      owner <= sel_ls ? OWN_LS : OWN_IF;
    end
  end

endmodule

//--- source/core_pkg.sv
package core_pkg;

  parameter int xlen       = 32;
  parameter int reg_addr_w = 4;
  parameter int reg_num    = 16;

  // Major opcodes with their RV32 encodings
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B,
    ALU_EQ,
    ALU_NE
  } alu_op_e;

endpackage

//--- source/core_top.sv
`timescale 1ns/100ps

module core_top
  import core_pkg::*;
#(
  parameter logic [xlen-1:0] reset_pc = '0
)
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  mem_ack_i,
  input  logic [xlen-1:0]       mem_rdata_i,
  output logic                  mem_req_o,
  output logic                  mem_we_o,
  output logic [xlen-1:0]       mem_addr_o,
  output logic [xlen-1:0]       mem_wdata_o,
  output logic [3:0]            mem_wstrb_o,
  output logic                  commit_valid_o,
  output logic [xlen-1:0]       commit_pc_o,
  output logic [reg_addr_w-1:0] commit_rd_o,
  output logic                  commit_we_o,
  output logic [xlen-1:0]       commit_wdata_o,
  output logic                  halt_o
);

  logic                  if_req, if_ack;
  logic [xlen-1:0]       if_addr, if_rdata;
  logic                  inst_valid;
  logic [31:0]           inst;
  logic [xlen-1:0]       fetch_pc;

  logic [reg_addr_w-1:0] raddr1, raddr2;
  logic [xlen-1:0]       rdata1, rdata2;
  logic                  rf_we;
  logic [reg_addr_w-1:0] rf_waddr;
  logic [xlen-1:0]       rf_wdata;

  logic                  dec_valid;
  opcode_e               opcode;
  alu_op_e               alu_op;
  logic [xlen-1:0]       op_a, op_b, store_data, imm, dec_pc;
  logic [reg_addr_w-1:0] rd;
  logic                  rd_we, illegal;

  logic                  exec_done;
  logic [xlen-1:0]       next_pc;
  logic                  ls_start, ex_ls_we, ls_done;
  logic [xlen-1:0]       ex_ls_addr, ex_ls_wdata, ls_result;

  logic                  ls_req, ls_we, ls_ack;
  logic [xlen-1:0]       ls_addr, ls_wdata, ls_rdata;

  fetch_unit #(.reset_pc(reset_pc)) u_fetch (
    .clk(clk), .rst(rst),
    .exec_done_i(exec_done), .next_pc_i(next_pc), .halt_i(halt_o),
    .if_ack_i(if_ack), .if_rdata_i(if_rdata),
    .if_req_o(if_req), .if_addr_o(if_addr),
    .inst_valid_o(inst_valid), .inst_o(inst), .pc_o(fetch_pc)
  );

  decode_unit u_decode (
    .clk(clk), .rst(rst),
    .inst_valid_i(inst_valid), .inst_i(inst), .pc_i(fetch_pc),
    .rdata1_i(rdata1), .rdata2_i(rdata2),
    .raddr1_o(raddr1), .raddr2_o(raddr2),
    .dec_valid_o(dec_valid), .opcode_o(opcode), .alu_op_o(alu_op),
    .op_a_o(op_a), .op_b_o(op_b), .store_data_o(store_data), .imm_o(imm),
    .rd_o(rd), .rd_we_o(rd_we), .pc_o(dec_pc), .illegal_o(illegal)
  );

  reg_file u_regs (
    .clk(clk), .rst(rst),
    .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata),
    .raddr1_i(raddr1), .raddr2_i(raddr2),
    .rdata1_o(rdata1), .rdata2_o(rdata2)
  );

  exec_unit u_exec (
    .clk(clk), .rst(rst),
    .dec_valid_i(dec_valid), .opcode_i(opcode), .alu_op_i(alu_op),
    .op_a_i(op_a), .op_b_i(op_b), .store_data_i(store_data), .imm_i(imm),
    .rd_i(rd), .rd_we_i(rd_we), .pc_i(dec_pc), .illegal_i(illegal),
    .ls_done_i(ls_done), .ls_rdata_i(ls_result),
    .ls_start_o(ls_start), .ls_we_o(ex_ls_we),
    .ls_addr_o(ex_ls_addr), .ls_wdata_o(ex_ls_wdata),
    .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
    .done_o(exec_done), .next_pc_o(next_pc),
    .commit_valid_o(commit_valid_o), .commit_pc_o(commit_pc_o),
    .commit_rd_o(commit_rd_o), .commit_we_o(commit_we_o),
    .commit_wdata_o(commit_wdata_o), .halt_o(halt_o)
  );

  load_store_unit u_lsu (
    .clk(clk), .rst(rst),
    .start_i(ls_start), .we_i(ex_ls_we), .addr_i(ex_ls_addr), .wdata_i(ex_ls_wdata),
    .ls_ack_i(ls_ack), .ls_rdata_i(ls_rdata),
    .ls_req_o(ls_req), .ls_we_o(ls_we), .ls_addr_o(ls_addr), .ls_wdata_o(ls_wdata),
    .done_o(ls_done), .rdata_o(ls_result)
  );

  bus_arbiter u_arb (
    .clk(clk), .rst(rst),
    .if_req_i(if_req), .if_addr_i(if_addr),
    .ls_req_i(ls_req), .ls_we_i(ls_we), .ls_addr_i(ls_addr), .ls_wdata_i(ls_wdata),
    .mem_ack_i(mem_ack_i), .mem_rdata_i(mem_rdata_i),
    .if_ack_o(if_ack), .if_rdata_o(if_rdata),
    .ls_ack_o(ls_ack), .ls_rdata_o(ls_rdata),
    .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
    .mem_wdata_o(mem_wdata_o), .mem_wstrb_o(mem_wstrb_o)
  );

endmodule

//--- source/decode_unit.sv
`timescale 1ns/100ps

module decode_unit
  import core_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inst_valid_i,
  input  logic [31:0]           inst_i,
  input  logic [xlen-1:0]       pc_i,
  input  logic [xlen-1:0]       rdata1_i,
  input  logic [xlen-1:0]       rdata2_i,
  output logic [reg_addr_w-1:0] raddr1_o,
  output logic [reg_addr_w-1:0] raddr2_o,
  output logic                  dec_valid_o,
  output opcode_e               opcode_o,
  output alu_op_e               alu_op_o,
  output logic [xlen-1:0]       op_a_o,
  output logic [xlen-1:0]       op_b_o,
  output logic [xlen-1:0]       store_data_o,
  output logic [xlen-1:0]       imm_o,
  output logic [reg_addr_w-1:0] rd_o,
  output logic                  rd_we_o,
  output logic [xlen-1:0]       pc_o,
  output logic                  illegal_o
);

  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  opcode_e         opc;
  alu_op_e         alu;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] imm;
  logic            writes;
  logic            bad;

  assign funct3   = inst_i[14:12];
  assign funct7   = inst_i[31:25];
  assign raddr1_o = inst_i[18:15];
  assign raddr2_o = inst_i[23:20];

  assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u = {inst_i[31:12], 12'b0};
  assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  always_comb
  begin
    opc    = SYSTEM;
    alu    = ALU_ADD;
    op_b   = rdata2_i;
    imm    = imm_i;
    writes = 1'b0;
    bad    = 1'b0;
    case (inst_i[6:0])
      OP_IMM:
      begin
        opc    = OP_IMM;
        op_b   = imm_i;
        writes = 1'b1;
        bad    = (funct3 != 3'b000);
      end
      OP:
      begin
        opc    = OP;
        writes = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: alu = ALU_ADD;
          {7'h20, 3'b000}: alu = ALU_SUB;
          {7'h00, 3'b111}: alu = ALU_AND;
          {7'h00, 3'b110}: alu = ALU_OR;
          {7'h00, 3'b100}: alu = ALU_XOR;
          default:         bad = 1'b1;
        endcase
      end
      LUI:
      begin
        opc    = LUI;
        alu    = ALU_PASS_B;
        op_b   = imm_u;
        imm    = imm_u;
        writes = 1'b1;
      end
      LOAD:
      begin
        opc    = LOAD;
        op_b   = imm_i;
        writes = 1'b1;
        bad    = (funct3 != 3'b010);
      end
      STORE:
      begin
        opc  = STORE;
        op_b = imm_s;
        imm  = imm_s;
        bad  = (funct3 != 3'b010);
      end
      BRANCH:
      begin
        opc = BRANCH;
        imm = imm_b;
        case (funct3)
          3'b000:  alu = ALU_EQ;
          3'b001:  alu = ALU_NE;
          default: bad = 1'b1;
        endcase
      end
      JAL:
      begin
        opc    = JAL;
        imm    = imm_j;
        writes = 1'b1;
      end
      SYSTEM:
      begin
        // Only EBREAK is supported
        bad = (inst_i != 32'h0010_0073);
      end
      default:
      begin
        bad = 1'b1;
      end
    endcase
    // RV32E has no x16 and above
    if (writes && inst_i[11])
    begin
      bad = 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      dec_valid_o <= 1'b0;
    end
    else
    begin
      dec_valid_o <= inst_valid_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (inst_valid_i)
    begin
      opcode_o     <= bad ? SYSTEM : opc;
      alu_op_o     <= alu;
      op_a_o       <= rdata1_i;
      op_b_o       <= op_b;
      store_data_o <= rdata2_i;
      imm_o        <= imm;
      rd_o         <= inst_i[10:7];
      rd_we_o      <= writes && !bad && (inst_i[11:7] != 5'd0);
      pc_o         <= pc_i;
      illegal_o    <= bad;
    end
  end

endmodule

//--- source/exec_unit.sv
`timescale 1ns/100ps

module exec_unit
  import core_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  dec_valid_i,
  input  opcode_e               opcode_i,
  input  alu_op_e               alu_op_i,
  input  logic [xlen-1:0]       op_a_i,
  input  logic [xlen-1:0]       op_b_i,
  input  logic [xlen-1:0]       store_data_i,
  input  logic [xlen-1:0]       imm_i,
  input  logic [reg_addr_w-1:0] rd_i,
  input  logic                  rd_we_i,
  input  logic [xlen-1:0]       pc_i,
  input  logic                  illegal_i,
  input  logic                  ls_done_i,
  input  logic [xlen-1:0]       ls_rdata_i,
  output logic                  ls_start_o,
  output logic                  ls_we_o,
  output logic [xlen-1:0]       ls_addr_o,
  output logic [xlen-1:0]       ls_wdata_o,
  output logic                  rf_we_o,
  output logic [reg_addr_w-1:0] rf_waddr_o,
  output logic [xlen-1:0]       rf_wdata_o,
  output logic                  done_o,
  output logic [xlen-1:0]       next_pc_o,
  output logic                  commit_valid_o,
  output logic [xlen-1:0]       commit_pc_o,
  output logic [reg_addr_w-1:0] commit_rd_o,
  output logic                  commit_we_o,
  output logic [xlen-1:0]       commit_wdata_o,
  output logic                  halt_o
);

  logic [xlen-1:0] alu_res;
  logic [xlen-1:0] pc_plus4;
  logic            is_mem;
  logic            taken;
  logic            fire;

  always_comb
  begin
    case (alu_op_i)
      ALU_SUB:    alu_res = op_a_i - op_b_i;
      ALU_AND:    alu_res = op_a_i & op_b_i;
      ALU_OR:     alu_res = op_a_i | op_b_i;
      ALU_XOR:    alu_res = op_a_i ^ op_b_i;
      ALU_PASS_B: alu_res = op_b_i;
      ALU_EQ:     alu_res = {{(xlen-1){1'b0}}, op_a_i == op_b_i};
      ALU_NE:     alu_res = {{(xlen-1){1'b0}}, op_a_i != op_b_i};
      default:    alu_res = op_a_i + op_b_i;
    endcase
  end

  assign pc_plus4 = pc_i + 32'd4;
  assign is_mem   = (opcode_i == LOAD || opcode_i == STORE) && !illegal_i;
  assign taken    = (opcode_i == BRANCH && alu_res[0]) || opcode_i == JAL;
  // Retire now, or when the memory access comes back
  assign fire     = (dec_valid_i && !is_mem) || ls_done_i;

  // Register write lands with the commit pulse
  assign rf_we_o    = commit_valid_o && commit_we_o;
  assign rf_waddr_o = commit_rd_o;
  assign rf_wdata_o = commit_wdata_o;
  assign done_o     = commit_valid_o;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ls_start_o     <= 1'b0;
      commit_valid_o <= 1'b0;
      halt_o         <= 1'b0;
    end
    else
    begin
      ls_start_o     <= dec_valid_i && is_mem;
      commit_valid_o <= fire;
      if (fire && (opcode_i == SYSTEM || illegal_i))
      begin
        halt_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (dec_valid_i && is_mem)
    begin
      ls_we_o    <= (opcode_i == STORE);
      ls_addr_o  <= alu_res;
      ls_wdata_o <= store_data_i;
    end
    if (fire)
    begin
      next_pc_o      <= taken ? pc_i + imm_i : pc_plus4;
      commit_pc_o    <= pc_i;
      commit_rd_o    <= rd_i;
      commit_we_o    <= rd_we_i;
      commit_wdata_o <= (opcode_i == JAL)  ? pc_plus4 :
                        (opcode_i == LOAD) ? ls_rdata_i : alu_res;
    end
  end

endmodule

//--- source/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit
  import core_pkg::*;
#(
  parameter logic [xlen-1:0] reset_pc = '0
)
(
  input  logic            clk,
  input  logic            rst,
  input  logic            exec_done_i,
  input  logic [xlen-1:0] next_pc_i,
  input  logic            halt_i,
  input  logic            if_ack_i,
  input  logic [xlen-1:0] if_rdata_i,
  output logic            if_req_o,
  output logic [xlen-1:0] if_addr_o,
  output logic            inst_valid_o,
  output logic [31:0]     inst_o,
  output logic [xlen-1:0] pc_o
);

  typedef enum logic [1:0] {IDLE, REQ, WAIT} state_e;

  state_e          state;
  logic [xlen-1:0] pc;

  // Request is held for the whole WAIT state
  assign if_req_o  = (state == WAIT);
  assign if_addr_o = pc;
  assign pc_o      = pc;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state        <= REQ;
      pc           <= reset_pc;
      inst_valid_o <= 1'b0;
    end
    else
    begin
      inst_valid_o <= 1'b0;
      case (state)
        REQ:
        begin
          state <= WAIT;
        end
        WAIT:
        begin
          if (if_ack_i)
          begin
            inst_o       <= if_rdata_i;
            inst_valid_o <= 1'b1;
            state        <= IDLE;
          end
        end
        default:
        begin
          if (exec_done_i)
          begin
            pc <= next_pc_i;
            // No further fetch once halted
            if (!halt_i)
            begin
              state <= WAIT;
            end
          end
        end
      endcase
    end
  end

endmodule

//--- source/load_store_unit.sv
`timescale 1ns/100ps

module load_store_unit
  import core_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            start_i,
  input  logic            we_i,
  input  logic [xlen-1:0] addr_i,
  input  logic [xlen-1:0] wdata_i,
  input  logic            ls_ack_i,
  input  logic [xlen-1:0] ls_rdata_i,
  output logic            ls_req_o,
  output logic            ls_we_o,
  output logic [xlen-1:0] ls_addr_o,
  output logic [xlen-1:0] ls_wdata_o,
  output logic            done_o,
  output logic [xlen-1:0] rdata_o
);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ls_req_o <= 1'b0;
      done_o   <= 1'b0;
    end
    else
    begin
      done_o <= 1'b0;
      if (start_i)
      begin
        ls_req_o <= 1'b1;
      end
      else if (ls_req_o && ls_ack_i)
      begin
        ls_req_o <= 1'b0;
        done_o   <= 1'b1;
      end
    end
  end

  // Access fields stay put until ack
  always_ff @(posedge clk)
  begin
    if (start_i)
    begin
      ls_we_o    <= we_i;
      ls_addr_o  <= addr_i;
      ls_wdata_o <= wdata_i;
    end
    if (ls_req_o && ls_ack_i)
    begin
      rdata_o <= ls_rdata_i;
    end
  end

endmodule

//--- source/reg_file.sv
`timescale 1ns/100ps

module reg_file
  import core_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  we_i,
  input  logic [reg_addr_w-1:0] waddr_i,
  input  logic [xlen-1:0]       wdata_i,
  input  logic [reg_addr_w-1:0] raddr1_i,
  input  logic [reg_addr_w-1:0] raddr2_i,
  output logic [xlen-1:0]       rdata1_o,
  output logic [xlen-1:0]       rdata2_o
);

  logic [xlen-1:0] regs [reg_num];

  // x0 reads as zero whatever the array holds
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < reg_num; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (we_i && waddr_i != '0)
    begin
      regs[waddr_i] <= wdata_i;
    end
  end

endmodule

//--- tb.f
source/core_pkg.sv
source/reg_file.sv
source/fetch_unit.sv
source/decode_unit.sv
source/exec_unit.sv
source/load_store_unit.sv
source/bus_arbiter.sv
source/core_top.sv
testbench/core_checker.sv
testbench/core_tb.sv

//--- testbench/core_checker.sv
`timescale 1ns/100ps

module core_checker
  import core_pkg::*;
#(
  parameter logic [xlen-1:0] reset_pc = '0
)
(
  input logic            clk,
  input logic            rst,
  input logic            mem_req_i,
  input logic            mem_we_i,
  input logic [xlen-1:0] mem_addr_i,
  input logic [xlen-1:0] mem_wdata_i,
  input logic            mem_ack_i,
  input logic            commit_valid_i,
  input logic            halt_i
);

  int fail_count = 0;

  reset_quiet: assert property (@(posedge clk)
    rst |=> !mem_req_i && !commit_valid_i && !halt_i)
  else
  begin
    $error("memory request, commit or halt high right after reset");
    fail_count++;
  end

  // First access is an instruction read at the reset PC
  first_fetch: assert property (@(posedge clk)
    $fell(rst) |=> mem_req_i && !mem_we_i && mem_addr_i == reset_pc)
  else
  begin
    $error("first request is not a read at the reset PC");
    fail_count++;
  end

  req_stable: assert property (@(posedge clk) disable iff (rst)
    mem_req_i && !mem_ack_i |=> mem_req_i && $stable(mem_addr_i) &&
                                $stable(mem_we_i) && $stable(mem_wdata_i))
  else
  begin
    $error("memory request dropped or changed before ack");
    fail_count++;
  end

  commit_gap: assert property (@(posedge clk) disable iff (rst)
    commit_valid_i |=> !commit_valid_i)
  else
  begin
    $error("two commits in back to back cycles");
    fail_count++;
  end

  halt_sticky: assert property (@(posedge clk) disable iff (rst)
    halt_i |=> halt_i && !mem_req_i && !commit_valid_i)
  else
  begin
    $error("core active or halt dropped after halting");
    fail_count++;
  end

endmodule

bind core_top core_checker #(.reset_pc(reset_pc)) u_chk (
  .clk(clk),
  .rst(rst),
  .mem_req_i(mem_req_o),
  .mem_we_i(mem_we_o),
  .mem_addr_i(mem_addr_o),
  .mem_wdata_i(mem_wdata_o),
  .mem_ack_i(mem_ack_i),
  .commit_valid_i(commit_valid_o),
  .halt_i(halt_o)
);

//--- testbench/core_tb.sv
`timescale 1ns/100ps

module core_tb;

  localparam logic [31:0] reset_pc       = 32'h0000_0040;
  localparam int          prog_base      = reset_pc[9:2];
  localparam int          timeout_cycles = 4000;
  localparam int          prog_len       = 29;
  localparam int          prog_commits   = 35;

  logic        clk = 1'b0;
  logic        rst;
  logic        mem_ack;
  logic [31:0] mem_rdata;
  logic        mem_req;
  logic        mem_we;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wstrb;
  logic        commit_valid;
  logic [31:0] commit_pc;
  logic [3:0]  commit_rd;
  logic        commit_we;
  logic [31:0] commit_wdata;
  logic        halt;

  logic [31:0] mem [256];
  logic [31:0] ref_regs [16];
  logic [31:0] ref_mem [256];
  logic [31:0] ref_pc;
  int          commit_count;
  int          cycle_count = 0;
  int          ack_delay;
  logic        req_pending;

  core_top #(.reset_pc(reset_pc)) core_top_i (
    .clk(clk), .rst(rst),
    .mem_ack_i(mem_ack), .mem_rdata_i(mem_rdata),
    .mem_req_o(mem_req), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
    .mem_wdata_o(mem_wdata), .mem_wstrb_o(mem_wstrb),
    .commit_valid_o(commit_valid), .commit_pc_o(commit_pc), .commit_rd_o(commit_rd),
    .commit_we_o(commit_we), .commit_wdata_o(commit_wdata), .halt_o(halt)
  );

  always #4 clk = ~clk;

  task automatic stop_on_error;
    $display("Errors found");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("ERR %s got %08h expected %08h", name, got, exp);
      stop_on_error();
    end
  endtask

  // Instruction encoders
  function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                         input int rd, input int opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                         input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                         input int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] u_type(input int imm20, input int rd);
    return {imm20[19:0], rd[4:0], 7'h37};
  endfunction

  function automatic logic [31:0] j_type(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  function automatic logic [31:0] program_word(input int idx);
    case (idx)
      0:  return i_type(5, 0, 0, 1, 7'h13);
      1:  return i_type(-3, 0, 0, 2, 7'h13);
      2:  return r_type(0, 2, 1, 0, 3);
      3:  return r_type(32, 2, 1, 0, 4);
      4:  return r_type(0, 2, 1, 7, 5);
      5:  return r_type(0, 2, 1, 6, 6);
      6:  return r_type(0, 2, 1, 4, 7);
      7:  return u_type(32'h12345, 8);
      8:  return i_type(32'h200, 0, 0, 9, 7'h13);
      9:  return s_type(0, 4, 9);
      10: return s_type(4, 8, 9);
      11: return i_type(0, 9, 2, 10, 7'h03);
      12: return i_type(4, 9, 2, 11, 7'h03);
      // Write to x0 must be dropped
      13: return i_type(7, 0, 0, 0, 7'h13);
      14: return i_type(4, 0, 0, 12, 7'h13);
      // Countdown loop
      15: return i_type(3, 13, 0, 13, 7'h13);
      16: return i_type(-1, 12, 0, 12, 7'h13);
      17: return b_type(-8, 0, 12, 1);
      18: return b_type(8, 0, 12, 0);
      19: return i_type(99, 0, 0, 14, 7'h13);
      20: return b_type(8, 2, 1, 0);
      21: return j_type(8, 15);
      22: return i_type(77, 0, 0, 14, 7'h13);
      23: return s_type(8, 13, 9);
      24: return i_type(8, 9, 2, 14, 7'h03);
      25: return j_type(8, 0);
      26: return i_type(1, 0, 0, 14, 7'h13);
      27: return s_type(12, 11, 9);
      28: return 32'h0010_0073;
      default: return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] initial_word(input int idx);
    if (idx >= prog_base && idx < prog_base + prog_len)
    begin
      return program_word(idx - prog_base);
    end
    return 32'ha5a5_0000 + idx;
  endfunction

  // Instruction set model stepped once per commit
  task automatic step_model;
    logic [31:0] inst;
    logic [31:0] ra;
    logic [31:0] rb;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] addr;
    logic [31:0] res;
    logic [31:0] nxt;
    logic [3:0]  rd;
    logic        we;
    inst  = ref_mem[ref_pc[9:2]];
    rd    = inst[10:7];
    ra    = ref_regs[inst[18:15]];
    rb    = ref_regs[inst[23:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    nxt   = ref_pc + 32'd4;
    res   = 32'h0;
    we    = 1'b0;
    case (inst[6:0])
      7'h13:
      begin
        we  = 1'b1;
        res = ra + imm_i;
      end
      7'h33:
      begin
        we = 1'b1;
        case ({inst[30], inst[14:12]})
          4'b0000: res = ra + rb;
          4'b1000: res = ra - rb;
          4'b0111: res = ra & rb;
          4'b0110: res = ra | rb;
          4'b0100: res = ra ^ rb;
          default: res = 32'h0;
        endcase
      end
      7'h37:
      begin
        we  = 1'b1;
        res = {inst[31:12], 12'h000};
      end
      7'h03:
      begin
        we   = 1'b1;
        addr = ra + imm_i;
        res  = ref_mem[addr[9:2]];
      end
      7'h23:
      begin
        addr = ra + imm_s;
        ref_mem[addr[9:2]] = rb;
      end
      7'h63:
      begin
        if ((!inst[12] && ra == rb) || (inst[12] && ra != rb))
        begin
          nxt = ref_pc + imm_b;
        end
      end
      7'h6f:
      begin
        we  = 1'b1;
        res = ref_pc + 32'd4;
        nxt = ref_pc + imm_j;
      end
      default: ;
    endcase
    if (rd == 4'd0)
    begin
      we = 1'b0;
    end
    expect_equal("commit_pc_o", commit_pc, ref_pc);
    expect_equal("commit_we_o", {31'b0, commit_we}, {31'b0, we});
    if (we)
    begin
      expect_equal("commit_rd_o", {28'b0, commit_rd}, {28'b0, rd});
      expect_equal("commit_wdata_o", commit_wdata, res);
      ref_regs[rd] = res;
    end
    ref_pc       = nxt;
    commit_count = commit_count + 1;
  endtask

  // Memory with a random ack delay of 0 to 3 cycles
  initial
  begin
    void'($urandom(32'h8e3d_1bbb));
    mem_ack     = 1'b0;
    mem_rdata   = 32'h0;
    req_pending = 1'b0;
    ack_delay   = 0;
    for (int i = 0; i < 256; i++)
    begin
      mem[i] = initial_word(i);
    end
    forever
    begin
      @(negedge clk);
      if (mem_ack)
      begin
        mem_ack = 1'b0;
      end
      else if (!rst && mem_req)
      begin
        if (!req_pending)
        begin
          req_pending = 1'b1;
          ack_delay   = $urandom_range(3, 0);
        end
        if (ack_delay == 0)
        begin
          req_pending = 1'b0;
          mem_ack     = 1'b1;
          if (mem_we)
          begin
            for (int b = 0; b < 4; b++)
            begin
              if (mem_wstrb[b])
              begin
                mem[mem_addr[9:2]][8*b +: 8] = mem_wdata[8*b +: 8];
              end
            end
          end
          else
          begin
            mem_rdata = mem[mem_addr[9:2]];
          end
        end
        else
        begin
          ack_delay = ack_delay - 1;
        end
      end
    end
  end

  initial
  begin
    for (int i = 0; i < 16; i++)
    begin
      ref_regs[i] = 32'h0;
    end
    for (int i = 0; i < 256; i++)
    begin
      ref_mem[i] = initial_word(i);
    end
    ref_pc       = reset_pc;
    commit_count = 0;
    forever
    begin
      @(negedge clk);
      if (!rst && commit_valid)
      begin
        step_model();
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (core_top_i.u_chk.fail_count != 0)
    begin
      $display("A bound assertion on the memory or commit port failed");
      stop_on_error();
    end
    else if (cycle_count >= timeout_cycles)
    begin
      $display("Timeout, the core did not halt within %0d cycles", cycle_count);
      stop_on_error();
    end
  end

  initial
  begin
    rst = 1'b1;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    while (!halt)
    begin
      @(negedge clk);
    end
    // Let the checker watch the halted core for a while
    repeat (4) @(negedge clk);
    expect_equal("commit_count", commit_count, prog_commits);
    for (int i = 0; i < 256; i++)
    begin
      expect_equal($sformatf("mem[%0d]", i), mem[i], ref_mem[i]);
    end
    if (core_top_i.u_chk.fail_count == 0)
    begin
      $display("No errors");
      $finish;
    end
    else
    begin
      $display("A bound assertion failed during the run");
      stop_on_error();
    end
  end

endmodule
